// File: logic/sd_byte_shifter.sv
`timescale 1ns/1ns
`include "sd_spi_consts.svh"

module sd_byte_shifter (
	input  logic                 spi_clk_i,
	input  logic                 spi_rst_i,
	input  logic                 run_i,
	input  logic                 msb_first_i, // 1: bit 7 goes out first
	input  logic                 sck_rise_i,
	input  logic                 sck_fall_i,
	input  logic                 miso_i,
	input  sd_spi_pkg::sd_byte_t tx_byte_i, // Loaded on the first fall of each byte
	output logic                 mosi_o,
	output logic                 byte_done_o,
	output sd_spi_pkg::sd_byte_t rx_byte_o // Valid with byte_done_o
);
	import sd_spi_pkg::*;

	sd_byte_t   tx_q; // Bits still to send
	sd_byte_t   rx_q; // Bits received so far
	sd_byte_t   tx_src; // Register to shift this fall
	sd_byte_t   tx_next;
	logic [2:0] bit_cnt_q; // Bit in flight, advanced on each rise
	logic       tx_bit;

	// New byte at bit 0, otherwise keep shifting
	assign tx_src = (bit_cnt_q == 3'd0) ? tx_byte_i : tx_q;

	// Pick the outgoing bit and refill with ones from the far end
	always_comb begin
		if (msb_first_i) begin
			tx_bit  = tx_src[7];
			tx_next = {tx_src[6:0], 1'b1};
		end else begin
			tx_bit  = tx_src[0];
			tx_next = {1'b1, tx_src[7:1]};
		end
	end

	// MISO enters at the end opposite the first bit
	assign rx_byte_o   = msb_first_i ? {rx_q[6:0], miso_i} : {miso_i, rx_q[7:1]};
	assign byte_done_o = sck_rise_i && (bit_cnt_q == 3'd7);

	always_ff @(posedge spi_clk_i or posedge spi_rst_i) begin
		if (spi_rst_i) begin
			tx_q      <= `SD_FILL_BYTE;
			rx_q      <= `SD_FILL_BYTE;
			bit_cnt_q <= 3'd0;
			mosi_o    <= 1'b1;
		end else if (!run_i) begin
			// Between frames MOSI idles high
			tx_q      <= `SD_FILL_BYTE;
			rx_q      <= `SD_FILL_BYTE;
			bit_cnt_q <= 3'd0;
			mosi_o    <= 1'b1;
		end else begin
			if (sck_fall_i) begin
				tx_q   <= tx_next;
				mosi_o <= tx_bit; // Changes with SCK going low
			end
			if (sck_rise_i) begin
				rx_q      <= rx_byte_o; // Sample while SCK goes high
				bit_cnt_q <= bit_cnt_q + 3'd1; // Wraps to 0 after bit 7
			end
		end
	end

endmodule

// File: logic/sd_frame_ctrl.sv
`timescale 1ns/1ns
`include "sd_spi_consts.svh"

module sd_frame_ctrl (
	input  logic                     spi_clk_i,
	input  logic                     spi_rst_i,
	input  logic                     enable_i,
	input  logic                     start_i,
	input  logic                     read_i, // Sampled at start
	input  logic                     cs_high_i, // CS level for this frame
	input  logic                     byte_done_i,
	input  sd_spi_pkg::sd_cmd_t      cmd_i,
	output logic                     run_o,
	output logic                     cs_o,
	output logic                     done_o,
	output logic                     frame_start_o,
	output logic                     read_active_o,
	output sd_spi_pkg::sd_byte_t     tx_byte_o,
	output sd_spi_pkg::sd_byte_idx_t byte_idx_o
);
	import sd_spi_pkg::*;

	// Last byte index per mode
	localparam sd_byte_idx_t CMD_LAST  = sd_byte_idx_t'(`SD_R1_BYTE);
	localparam sd_byte_idx_t READ_LAST =
		sd_byte_idx_t'(`SD_DATA_BYTE0 + (`SD_WORD_W / 8) * `SD_READ_WORDS - 1);
	localparam sd_byte_idx_t CMD_BYTES = sd_byte_idx_t'(`SD_CMD_BYTES);

	sd_state_e    state_q, state_d;
	sd_byte_idx_t byte_cnt_q; // Byte currently on the wire
	sd_cmd_t      cmd_sh; // Command with current byte at the top
	logic         read_q; // Frame is a read
	logic         cs_q;
	logic         frame_start_q;
	logic         start_go; // Accepted start
	logic         last_byte; // Current byte ends the frame

	assign start_go  = (state_q == SD_IDLE) && enable_i && start_i;
	assign last_byte = byte_cnt_q == (read_q ? READ_LAST : CMD_LAST);

	// Next state
	always_comb begin
		state_d = state_q;
		case (state_q)
			SD_IDLE: begin
				if (start_go)
					state_d = SD_XFER;
			end
			SD_XFER: begin
				if (byte_done_i && last_byte)
					state_d = SD_FINISH;
			end
			SD_FINISH: state_d = SD_IDLE; // Single done cycle
			default:   state_d = SD_IDLE;
		endcase
	end

	always_ff @(posedge spi_clk_i or posedge spi_rst_i) begin
		if (spi_rst_i) begin
			state_q       <= SD_IDLE;
			byte_cnt_q    <= '0;
			read_q        <= 1'b0;
			cs_q          <= 1'b0;
			frame_start_q <= 1'b0;
		end else begin
			state_q       <= state_d;
			frame_start_q <= start_go; // High in the first XFER cycle
			if (start_go) begin
				byte_cnt_q <= '0;
				read_q     <= read_i;
				cs_q       <= cs_high_i; // Held for the whole frame
			end else if (state_q == SD_XFER && byte_done_i && !last_byte) begin
				byte_cnt_q <= byte_cnt_q + 1'b1;
			end
			if (state_q == SD_FINISH)
				cs_q <= 1'b0; // Low again once back in idle
		end
	end

	// Command bytes MSB byte first, then fill
	assign cmd_sh    = cmd_i << {byte_cnt_q, 3'b000};
	assign tx_byte_o = (byte_cnt_q < CMD_BYTES) ? cmd_sh[`SD_CMD_W-1 -: 8] : `SD_FILL_BYTE;

	assign run_o         = state_q == SD_XFER; // SCK only runs here
	assign cs_o          = cs_q;
	assign done_o        = state_q == SD_FINISH;
	assign frame_start_o = frame_start_q;
	assign read_active_o = read_q && (state_q == SD_XFER);
	assign byte_idx_o    = byte_cnt_q;

endmodule

// File: logic/sd_resp_capture.sv
`timescale 1ns/1ns
`include "sd_spi_consts.svh"

module sd_resp_capture (
	input  logic                     spi_clk_i,
	input  logic                     spi_rst_i,
	input  logic                     byte_done_i,
	input  logic                     frame_start_i, // Drops any partial word
	input  logic                     read_active_i,
	input  sd_spi_pkg::sd_byte_idx_t byte_idx_i,
	input  sd_spi_pkg::sd_byte_t     rx_byte_i,
	output sd_spi_pkg::sd_byte_t     r1_o,
	output sd_spi_pkg::sd_word_t     data_o,
	output logic                     word_done_o // Pulses with each data_o update
);
	import sd_spi_pkg::*;

	sd_word_t     word_q; // Partial word, first byte ends up on top
	sd_word_t     word_next;
	sd_byte_idx_t data_off; // Offset from first data byte
	logic         data_byte; // Completed byte belongs to the read data
	logic         word_last; // Fourth byte of a word

	assign data_off  = byte_idx_i - sd_byte_idx_t'(`SD_DATA_BYTE0);
	assign data_byte = byte_done_i && read_active_i &&
		(byte_idx_i >= sd_byte_idx_t'(`SD_DATA_BYTE0));
	assign word_last = data_byte && (data_off[1:0] == 2'd3);
	assign word_next = {word_q[`SD_WORD_W-9:0], rx_byte_i};

	// Byte assembly
	always_ff @(posedge spi_clk_i) begin
		if (frame_start_i)
			word_q <= '0;
		else if (data_byte)
			word_q <= word_next;
	end

	always_ff @(posedge spi_clk_i or posedge spi_rst_i) begin
		if (spi_rst_i) begin
			r1_o        <= '0;
			data_o      <= '0;
			word_done_o <= 1'b0;
		end else begin
			// R1 sits in the last fill byte of every frame
			if (byte_done_i && byte_idx_i == sd_byte_idx_t'(`SD_R1_BYTE))
				r1_o <= rx_byte_i;
			word_done_o <= word_last;
			if (word_last)
				data_o <= word_next; // Publish the full word
		end
	end

endmodule

// File: logic/sd_sck_gen.sv
`timescale 1ns/1ns
`include "sd_spi_consts.svh"

module sd_sck_gen (
	input  logic                spi_clk_i,
	input  logic                spi_rst_i,
	input  logic                run_i, // High while a frame is on the wire
	input  sd_spi_pkg::sd_div_e div_sel_i,
	output logic                sck_o,
	output logic                sck_rise_o, // SCK goes high at the end of this cycle
	output logic                sck_fall_o // SCK goes low at the end of this cycle
);
	import sd_spi_pkg::*;

	logic [`SD_DIV_CNT_W-1:0] div_cnt_q; // Clocks in the current half period
	logic [`SD_DIV_CNT_W-1:0] half_m1; // Half period minus one
	logic                     phase_q; // 0: next edge is a fall, 1: a rise
	logic                     terminal; // Half period elapsed

	// Divider code to terminal count
	always_comb begin
		case (div_sel_i)
			DIV_1:   half_m1 = `SD_DIV_CNT_W'd0;
			DIV_2:   half_m1 = `SD_DIV_CNT_W'd1;
			DIV_4:   half_m1 = `SD_DIV_CNT_W'd3;
			DIV_8:   half_m1 = `SD_DIV_CNT_W'd7;
			default: half_m1 = `SD_DIV_CNT_W'd15; // DIV_16 and unused codes
		endcase
	end

	assign terminal   = run_i && (div_cnt_q == half_m1);
	assign sck_rise_o = terminal && phase_q;
	assign sck_fall_o = terminal && !phase_q; // First one only sets up MOSI

	always_ff @(posedge spi_clk_i or posedge spi_rst_i) begin
		if (spi_rst_i) begin
			div_cnt_q <= '0;
			phase_q   <= 1'b0;
			sck_o     <= 1'b0;
		end else if (!run_i) begin
			// Idle, SCK parked low and count restarts
			div_cnt_q <= '0;
			phase_q   <= 1'b0;
			sck_o     <= 1'b0;
		end else if (terminal) begin
			div_cnt_q <= '0;
			phase_q   <= ~phase_q;
			sck_o     <= phase_q; // Rise drives 1, fall drives 0
		end else begin
			div_cnt_q <= div_cnt_q + 1'b1;
		end
	end

endmodule

// File: logic/sd_spi_consts.svh
`ifndef SD_SPI_CONSTS_SVH
`define SD_SPI_CONSTS_SVH

// Command frame layout
`define SD_CMD_BYTES 6 // Command bytes, sent MSB byte first
`define SD_CMD_W 48 // Command width in bits

// Read path
`define SD_WORD_W 32 // Width of one assembled read word
`define SD_READ_WORDS 4 // Words returned by one read frame

// Byte positions inside a frame
`define SD_R1_BYTE 7 // R1 comes back in the second fill byte
`define SD_DATA_BYTE0 8 // First data byte of a read

// Counter widths
`define SD_BYTE_CNT_W 6 // Byte index, covers the longest frame
`define SD_DIV_CNT_W 5 // SCK divider count, up to 15

// MOSI idle level and fill byte
`define SD_FILL_BYTE 8'hFF

`endif

// File: logic/sd_spi_pkg.sv
`include "sd_spi_consts.svh"

package sd_spi_pkg;

	// Frame FSM
	typedef enum logic [1:0] {
		SD_IDLE   = 2'd0, // Waiting for start
		SD_XFER   = 2'd1, // Bytes on the wire
		SD_FINISH = 2'd2  // Done pulse, back to idle
	} sd_state_e;

	// SCK divider codes, half period is 2**code clocks
	typedef enum logic [2:0] {
		DIV_1  = 3'd0,
		DIV_2  = 3'd1,
		DIV_4  = 3'd2,
		DIV_8  = 3'd3,
		DIV_16 = 3'd4
	} sd_div_e;

	// Data types
	typedef logic [`SD_CMD_W-1:0]      sd_cmd_t; // Full command frame
	typedef logic [`SD_WORD_W-1:0]     sd_word_t; // One read word
	typedef logic [7:0]                sd_byte_t; // Single byte on the wire
	typedef logic [`SD_BYTE_CNT_W-1:0] sd_byte_idx_t; // Byte position in frame

endpackage

// File: logic/spi_microsd_top.sv
`timescale 1ns/1ns

module spi_microsd_top (
	input  logic                 spi_clk_i,
	input  logic                 spi_rst_i,
	input  logic                 enable_i,
	input  logic                 start_i,
	input  logic                 read_i,
	input  logic                 msb_first_i,
	input  logic                 cs_high_i,
	input  sd_spi_pkg::sd_div_e  div_sel_i,
	input  sd_spi_pkg::sd_cmd_t  cmd_i,
	input  logic                 miso_i,
	output logic                 sck_o,
	output logic                 mosi_o,
	output logic                 cs_o,
	output logic                 done_o,
	output logic                 word_done_o,
	output sd_spi_pkg::sd_byte_t r1_o,
	output sd_spi_pkg::sd_word_t data_o
);
	import sd_spi_pkg::*;

	logic         run; // Frame on the wire
	logic         sck_rise, sck_fall;
	logic         byte_done;
	logic         frame_start;
	logic         read_active;
	sd_byte_t     tx_byte, rx_byte;
	sd_byte_idx_t byte_idx;

	sd_sck_gen u_sck_gen (
		.spi_clk_i (spi_clk_i),
		.spi_rst_i (spi_rst_i),
		.run_i     (run),
		.div_sel_i (div_sel_i),
		.sck_o     (sck_o),
		.sck_rise_o(sck_rise),
		.sck_fall_o(sck_fall)
	);

	sd_byte_shifter u_shifter (
		.spi_clk_i  (spi_clk_i),
		.spi_rst_i  (spi_rst_i),
		.run_i      (run),
		.msb_first_i(msb_first_i),
		.sck_rise_i (sck_rise),
		.sck_fall_i (sck_fall),
		.miso_i     (miso_i),
		.tx_byte_i  (tx_byte),
		.mosi_o     (mosi_o),
		.byte_done_o(byte_done),
		.rx_byte_o  (rx_byte)
	);

	sd_frame_ctrl u_frame_ctrl (
		.spi_clk_i    (spi_clk_i),
		.spi_rst_i    (spi_rst_i),
		.enable_i     (enable_i),
		.start_i      (start_i),
		.read_i       (read_i),
		.cs_high_i    (cs_high_i),
		.byte_done_i  (byte_done),
		.cmd_i        (cmd_i),
		.run_o        (run),
		.cs_o         (cs_o),
		.done_o       (done_o),
		.frame_start_o(frame_start),
		.read_active_o(read_active),
		.tx_byte_o    (tx_byte),
		.byte_idx_o   (byte_idx)
	);

	sd_resp_capture u_resp_capture (
		.spi_clk_i    (spi_clk_i),
		.spi_rst_i    (spi_rst_i),
		.byte_done_i  (byte_done),
		.frame_start_i(frame_start),
		.read_active_i(read_active),
		.byte_idx_i   (byte_idx),
		.rx_byte_i    (rx_byte),
		.r1_o         (r1_o),
		.data_o       (data_o),
		.word_done_o  (word_done_o)
	);

endmodule

// File: run_sim.sh
#!/bin/sh
# Build with Verilator and run; the verdict comes from the simulation output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
	--top-module tb_spi_microsd -f sources.f \
	&& ./obj_dir/Vtb_spi_microsd | tee /dev/stderr | grep -q "^Result: PASSED$" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// File: sources.f
+incdir+logic
logic/sd_spi_pkg.sv
logic/sd_sck_gen.sv
logic/sd_byte_shifter.sv
logic/sd_frame_ctrl.sv
logic/sd_resp_capture.sv
logic/spi_microsd_top.sv
testbench/sd_card_model.sv
testbench/sd_spi_chk.sv
testbench/tb_spi_microsd.sv

// File: testbench/sd_card_model.sv
`timescale 1ns/1ns
`include "sd_spi_consts.svh"

module sd_card_model #(
	parameter int FRAME_BYTES = `SD_DATA_BYTE0 + (`SD_WORD_W / 8) * `SD_READ_WORDS
) (
	input  logic                 clear_i, // Back to byte 0, bit 0
	input  logic                 msb_first_i,
	input  logic                 sck_i,
	input  logic                 mosi_i,
	output logic                 miso_o,
	input  sd_spi_pkg::sd_byte_t tx_bytes_i [FRAME_BYTES], // Card answer per byte
	output sd_spi_pkg::sd_byte_t rx_bytes_o [FRAME_BYTES] // Bytes seen on MOSI
);
	import sd_spi_pkg::*;

	int         byte_q; // Byte in flight
	logic [2:0] bit_q; // Bit in flight
	sd_byte_t   sh_q; // MOSI bits of the current byte
	sd_byte_t   sh_next;

	// Next bit is presented after each falling SCK
	always @(negedge sck_i or posedge clear_i) begin
		if (clear_i) begin
			bit_q  <= 3'd0;
			byte_q <= 0;
		end else begin
			bit_q <= bit_q + 3'd1;
			if (bit_q == 3'd7)
				byte_q <= byte_q + 1; // Byte boundary
		end
	end

	// Bit 0 is already on MISO before the first rise
	assign miso_o = (byte_q < FRAME_BYTES) ?
		tx_bytes_i[byte_q][msb_first_i ? 3'd7 - bit_q : bit_q] : 1'b1;

	assign sh_next = msb_first_i ? {sh_q[6:0], mosi_i} : {mosi_i, sh_q[7:1]};

	// MOSI latched on rising SCK
	always @(posedge sck_i or posedge clear_i) begin
		if (clear_i) begin
			sh_q <= '0;
			for (int i = 0; i < FRAME_BYTES; i++)
				rx_bytes_o[i] <= '0; // Missing bytes show up as zero
		end else begin
			sh_q <= sh_next;
			if (bit_q == 3'd7 && byte_q < FRAME_BYTES)
				rx_bytes_o[byte_q] <= sh_next;
		end
	end

endmodule

// File: testbench/sd_spi_chk.sv
`timescale 1ns/1ns

module sd_spi_chk (
	input logic spi_clk_i,
	input logic spi_rst_i,
	input logic run_i, // SCK generator running
	input logic read_active_i,
	input logic sck_i,
	input logic cs_i,
	input logic done_i,
	input logic word_done_i
);

	int fail_cnt = 0; // Assertions that fired so far

	// Done lasts one clock
	done_single: assert property (@(posedge spi_clk_i) disable iff (spi_rst_i)
		done_i |=> !done_i)
		else begin
			fail_cnt++;
			$error("done_o high for more than one cycle");
		end

	// SCK parked low outside a frame
	sck_parked: assert property (@(posedge spi_clk_i) disable iff (spi_rst_i)
		!$past(run_i) |-> !sck_i)
		else begin
			fail_cnt++;
			$error("sck_o high while no frame runs");
		end

	cs_held: assert property (@(posedge spi_clk_i) disable iff (spi_rst_i)
		run_i && $past(run_i) |-> $stable(cs_i))
		else begin
			fail_cnt++;
			$error("cs_o changed during a frame");
		end

	// Word flag one clock after a read byte
	word_in_read: assert property (@(posedge spi_clk_i) disable iff (spi_rst_i)
		word_done_i |-> $past(read_active_i))
		else begin
			fail_cnt++;
			$error("word_done_o outside a read frame");
		end

endmodule

// File: testbench/tb_spi_microsd.sv
`timescale 1ns/1ns
`include "sd_spi_consts.svh"

module tb_spi_microsd;
	import sd_spi_pkg::*;

	localparam int FRAME_BYTES = `SD_DATA_BYTE0 + (`SD_WORD_W / 8) * `SD_READ_WORDS;
	localparam int N_ROWS      = 8;

	// One stimulus row
	typedef struct packed {
		sd_cmd_t cmd;
		logic    rd; // Read frame
		logic    msb;
		sd_div_e div;
		logic    cs_high;
	} row_t;

	logic        spi_clk_i, spi_rst_i;
	logic        enable_i, start_i, read_i, msb_first_i, cs_high_i;
	sd_div_e     div_sel_i;
	sd_cmd_t     cmd_i;
	logic        miso_i, sck_o, mosi_o, cs_o, done_o, word_done_o;
	sd_byte_t    r1_o;
	sd_word_t    data_o;
	logic        card_clear;
	sd_byte_t    card_tx [FRAME_BYTES]; // Card answer
	sd_byte_t    card_rx [FRAME_BYTES]; // What the card saw
	row_t        rows [N_ROWS];
	logic [31:0] lfsr_q = 32'hb723_f827;
	int          cycle_cnt = 0;
	int          cycle_limit;

	spi_microsd_top UUT (.*);

	sd_card_model #(.FRAME_BYTES(FRAME_BYTES)) card (
		.clear_i    (card_clear),
		.msb_first_i(msb_first_i),
		.sck_i      (sck_o),
		.mosi_i     (mosi_o),
		.miso_o     (miso_i),
		.tx_bytes_i (card_tx),
		.rx_bytes_o (card_rx)
	);

	bind spi_microsd_top sd_spi_chk u_chk (
		.spi_clk_i    (spi_clk_i),
		.spi_rst_i    (spi_rst_i),
		.run_i        (run),
		.read_active_i(read_active),
		.sck_i        (sck_o),
		.cs_i         (cs_o),
		.done_i       (done_o),
		.word_done_i  (word_done_o)
	);

	initial begin
		spi_clk_i = 1'b0;
		forever #2 spi_clk_i = ~spi_clk_i;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1); // Galois form
	endfunction

	task automatic rand_byte(output sd_byte_t b);
		b = '0;
		for (int i = 0; i < 8; i++) begin
			b      = {b[6:0], lfsr_q[0]}; // One step per bit
			lfsr_q = lfsr_next(lfsr_q);
		end
	endtask

	// SCK clocks for a whole frame, 16 half periods per byte
	function automatic int frame_cycles(input row_t row);
		return (row.rd ? FRAME_BYTES : `SD_R1_BYTE + 1) * 16 * (1 << int'(row.div));
	endfunction

	task automatic abort_run();
		$display("Result: FAILED");
		$fatal(1);
	endtask

	task automatic check_byte(input string name, input sd_byte_t got, input sd_byte_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_word(input string name, input sd_word_t got, input sd_word_t exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		if (got != exp) begin
			$display("Error at %0t ns: %s = %0d, expected %0d", $time, name, got, exp);
			abort_run();
		end
	endtask

	task automatic run_row(input int r);
		row_t     row;
		sd_byte_t exp_mosi;
		sd_word_t exp_word;
		int       n_bytes, half, n, words, b, last_tgl, tgl_cnt;
		logic     sck_prev, fin;
		row     = rows[r];
		n_bytes = row.rd ? FRAME_BYTES : `SD_R1_BYTE + 1;
		half    = 1 << int'(row.div);
		for (int i = 0; i < FRAME_BYTES; i++) begin
			if (i == `SD_R1_BYTE || (row.rd && i >= `SD_DATA_BYTE0))
				rand_byte(card_tx[i]);
			else
				card_tx[i] = `SD_FILL_BYTE; // Card idles high
		end
		@(posedge spi_clk_i);
		#1 card_clear = 1'b1;
		@(posedge spi_clk_i);
		#1 card_clear = 1'b0;
		cmd_i       = row.cmd;
		read_i      = row.rd;
		msb_first_i = row.msb;
		div_sel_i   = row.div;
		cs_high_i   = row.cs_high;
		start_i     = 1'b1;
		n        = 0;
		words    = 0;
		tgl_cnt  = 0;
		last_tgl = 0;
		sck_prev = 1'b0;
		fin      = 1'b0;
		while (!fin) begin
			@(posedge spi_clk_i);
			#1 start_i = (n == 2); // Second start in mid-frame
			cs_high_i = (n == 2) ? !row.cs_high : row.cs_high;
			@(negedge spi_clk_i);
			n++;
			check_bit("cs_o", cs_o, row.cs_high);
			if (sck_o !== sck_prev) begin
				tgl_cnt++;
				if (tgl_cnt > 1)
					check_count("sck_o half period", n - last_tgl, half);
				last_tgl = n;
				sck_prev = sck_o;
			end
			if (word_done_o) begin
				if (!row.rd || words >= `SD_READ_WORDS) begin
					$display("Unexpected word_done_o pulse in row %0d at %0t ns", r, $time);
					abort_run();
				end else begin
					b        = `SD_DATA_BYTE0 + 4 * words; // First byte lands on top
					exp_word = {card_tx[b], card_tx[b + 1], card_tx[b + 2], card_tx[b + 3]};
					check_word("data_o", data_o, exp_word);
					words++;
				end
			end
			fin = done_o;
		end
		check_count("frame cycles", n, frame_cycles(row) + 1); // Plus the done cycle
		check_count("sck_o edges", tgl_cnt, 16 * n_bytes - 1); // Last fall after done
		check_byte("r1_o", r1_o, card_tx[`SD_R1_BYTE]);
		check_count("word_done_o pulses", words, row.rd ? `SD_READ_WORDS : 0);
		for (int i = 0; i < n_bytes; i++) begin
			exp_mosi = (i < `SD_CMD_BYTES) ? row.cmd[`SD_CMD_W - 1 - 8 * i -: 8] : `SD_FILL_BYTE;
			check_byte($sformatf("mosi_o byte %0d", i), card_rx[i], exp_mosi);
		end
		@(negedge spi_clk_i);
		check_bit("cs_o", cs_o, 1'b0);
		check_bit("done_o", done_o, 1'b0);
		check_bit("sck_o", sck_o, 1'b0);
	endtask

	// Timeout watchdog
	always @(posedge spi_clk_i) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= cycle_limit) begin
			$display("Timeout: the test did not finish within %0d cycles", cycle_limit);
			abort_run();
		end
	end

	initial begin
		spi_rst_i   = 1'b1;
		enable_i    = 1'b0;
		start_i     = 1'b0;
		read_i      = 1'b0;
		msb_first_i = 1'b1;
		cs_high_i   = 1'b0;
		div_sel_i   = DIV_1;
		cmd_i       = '0;
		card_clear  = 1'b1;
		for (int i = 0; i < FRAME_BYTES; i++)
			card_tx[i] = `SD_FILL_BYTE;
		rows[0] = '{48'h40_0000_0000_95, 1'b0, 1'b1, DIV_4, 1'b1}; // CMD0 with CS high
		rows[1] = '{48'h48_0000_01AA_87, 1'b0, 1'b0, DIV_1, 1'b0}; // CMD8
		rows[2] = '{48'h51_0000_0000_55, 1'b1, 1'b1, DIV_1, 1'b0}; // CMD17 reads
		rows[3] = '{48'h51_0000_0200_E1, 1'b1, 1'b0, DIV_2, 1'b0};
		rows[4] = '{48'h77_0000_0000_65, 1'b0, 1'b1, DIV_8, 1'b0}; // CMD55
		rows[5] = '{48'h69_4000_0000_77, 1'b0, 1'b0, DIV_16, 1'b1};
		rows[6] = '{48'h51_0000_0400_3B, 1'b1, 1'b1, DIV_16, 1'b0};
		rows[7] = '{48'h7A_0000_0000_FD, 1'b1, 1'b0, DIV_8, 1'b1};
		cycle_limit = 64;
		foreach (rows[r])
			cycle_limit += frame_cycles(rows[r]) + 16;
		repeat (2) @(posedge spi_clk_i);
		@(negedge spi_clk_i);
		check_bit("sck_o", sck_o, 1'b0); // Reset values
		check_bit("mosi_o", mosi_o, 1'b1);
		check_bit("cs_o", cs_o, 1'b0);
		check_bit("done_o", done_o, 1'b0);
		check_bit("word_done_o", word_done_o, 1'b0);
		check_byte("r1_o", r1_o, 8'h00);
		check_word("data_o", data_o, 32'h0);
		@(posedge spi_clk_i);
		#1 spi_rst_i = 1'b0;
		card_clear = 1'b0;
		enable_i   = 1'b1;
		foreach (rows[r])
			run_row(r);
		if (UUT.u_chk.fail_cnt == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule
